//--- bank_cfg_pkg.sv
// Widths are fixed for 16 IDs and at most 32 slots and every message carries its ID in the low bits
package bank_cfg_pkg;

  // Transaction ID taken from the low message bits
  localparam int unsigned IdWidth = 4;
  localparam int unsigned NumIds = 1 << IdWidth;

  // Upper bound of the slot pool that a top level may use in part
  localparam int unsigned SlotWidth = 5;
  localparam int unsigned MaxSlots = 1 << SlotWidth;

  localparam int unsigned MsgWidth = 64;

  typedef logic [IdWidth-1:0] id_t;

  typedef logic [SlotWidth-1:0] slot_t;

  // Low IdWidth bits hold the transaction ID
  typedef logic [MsgWidth-1:0] msg_t;

  // One bit per slot for enables, occupancy and release reports
  typedef logic [MaxSlots-1:0] slot_mask_t;

  typedef logic [NumIds-1:0] id_mask_t;

  // One extra bit so that a full pool fits
  typedef logic [SlotWidth:0] count_t;

endpackage

//--- bank_xfer_pkg.sv
// Grouped signals between the bank modules and every field width comes from bank_cfg_pkg
package bank_xfer_pkg;

  // Store of one message into the message RAM
  typedef struct packed {
    logic                 en;
    bank_cfg_pkg::slot_t  addr;
    bank_cfg_pkg::msg_t   data;
  } msg_wr_t;

  // Entry chosen for release on this cycle
  typedef struct packed {
    logic                 valid;
    bank_cfg_pkg::id_t    id;
    bank_cfg_pkg::slot_t  slot;
  } rel_sel_t;

  // Oldest stored entry of every ID
  typedef struct packed {
    bank_cfg_pkg::id_mask_t                          has_msg;
    bank_cfg_pkg::slot_t [bank_cfg_pkg::NumIds-1:0]  head;
  } list_head_t;

endpackage

//--- id_list_ctrl.sv
// One linked list per ID in a shared pool and slots must be released in the order they were stored
`timescale 1ns/1ps

module id_list_ctrl #(
  parameter int unsigned NumSlots = bank_cfg_pkg::MaxSlots
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      resv_fire_i,
  input  bank_cfg_pkg::id_t         resv_id_i,
  input  bank_cfg_pkg::slot_t       resv_slot_i,
  input  logic                      in_valid_i,
  input  bank_cfg_pkg::msg_t        in_data_i,
  output logic                      in_ready_o,
  output bank_xfer_pkg::msg_wr_t    wr_o,
  input  bank_xfer_pkg::rel_sel_t   sel_i,
  output bank_xfer_pkg::list_head_t heads_o
);
  import bank_cfg_pkg::*;

  // Link from each slot to the next slot of the same ID
  slot_t    next_ptr_q [NumSlots];

  // Per-ID last reserved, oldest empty and oldest reserved slots
  slot_t    tail_q [NumIds];
  slot_t    tail_d [NumIds];
  slot_t    fill_q [NumIds];
  slot_t    fill_d [NumIds];
  slot_t    rel_q [NumIds];
  slot_t    rel_d [NumIds];

  // Reserved count includes the stored entries
  count_t   resv_cnt_q [NumIds];
  count_t   resv_cnt_d [NumIds];
  count_t   stored_cnt_q [NumIds];
  count_t   stored_cnt_d [NumIds];

  id_t      in_id;
  logic     store_fire;
  id_mask_t has_empty;
  id_mask_t resv_hit;
  id_mask_t store_hit;
  id_mask_t pick_hit;
  slot_t    store_next;
  slot_t    pick_next;

  assign in_id = id_t'(in_data_i[IdWidth-1:0]);

  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      has_empty[i] = resv_cnt_q[i] != stored_cnt_q[i];
    end
  end

  // Ready depends on valid
  assign in_ready_o = in_valid_i && has_empty[in_id];
  assign store_fire = in_ready_o;

  assign wr_o = '{en: store_fire, addr: fill_q[in_id], data: in_data_i};

  always_comb begin
    resv_hit  = '0;
    store_hit = '0;
    pick_hit  = '0;
    resv_hit[resv_id_i] = resv_fire_i;
    store_hit[in_id]    = store_fire;
    pick_hit[sel_i.id]  = sel_i.valid;
  end

  // Two reads of the link array per cycle
  assign store_next = next_ptr_q[fill_q[in_id]];
  assign pick_next  = next_ptr_q[rel_q[sel_i.id]];

  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      tail_d[i]       = tail_q[i];
      fill_d[i]       = fill_q[i];
      rel_d[i]        = rel_q[i];
      resv_cnt_d[i]   = resv_cnt_q[i] + count_t'(resv_hit[i]) - count_t'(pick_hit[i]);
      stored_cnt_d[i] = stored_cnt_q[i] + count_t'(store_hit[i]) - count_t'(pick_hit[i]);

      // Pointer goes stale when the list runs dry until the next reservation
      if (pick_hit[i]) begin
        rel_d[i] = pick_next;
      end
      if (store_hit[i]) begin
        fill_d[i] = store_next;
      end

      if (resv_hit[i]) begin
        tail_d[i] = resv_slot_i;
        // List empty after this cycle's release
        if (resv_cnt_q[i] == count_t'(pick_hit[i])) begin
          rel_d[i] = resv_slot_i;
        end
        // Fill pointer caught up with a link that is not written yet
        if (resv_cnt_q[i] - stored_cnt_q[i] == count_t'(store_hit[i])) begin
          fill_d[i] = resv_slot_i;
        end
      end
    end
  end

  // Only link behind a live tail since a stale one may belong to another ID by now
  always_ff @(posedge clk_i) begin
    if (resv_fire_i && (resv_cnt_q[resv_id_i] != '0)) begin
      next_ptr_q[tail_q[resv_id_i]] <= resv_slot_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumIds; i++) begin
        tail_q[i]       <= '0;
        fill_q[i]       <= '0;
        rel_q[i]        <= '0;
        resv_cnt_q[i]   <= '0;
        stored_cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumIds; i++) begin
        tail_q[i]       <= tail_d[i];
        fill_q[i]       <= fill_d[i];
        rel_q[i]        <= rel_d[i];
        resv_cnt_q[i]   <= resv_cnt_d[i];
        stored_cnt_q[i] <= stored_cnt_d[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      heads_o.has_msg[i] = stored_cnt_q[i] != '0;
      heads_o.head[i]    = rel_q[i];
    end
  end

  a_store_needs_reservation: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_fire |-> (resv_cnt_q[in_id] > stored_cnt_q[in_id]));

endmodule

//--- msg_ram_2p.sv
// Message RAM without reset and a slot must not be written and read on the same cycle
`timescale 1ns/1ps

module msg_ram_2p #(
  parameter int unsigned NumSlots = bank_cfg_pkg::MaxSlots
) (
  input  logic                    clk_i,
  input  bank_xfer_pkg::msg_wr_t  wr_i,
  input  bank_xfer_pkg::rel_sel_t sel_i,
  output bank_cfg_pkg::msg_t      rd_data_o
);
  import bank_cfg_pkg::*;

  msg_t mem_q [NumSlots];
  msg_t rd_data_q;

  // Write port
  always_ff @(posedge clk_i) begin
    if (wr_i.en) begin
      mem_q[wr_i.addr] <= wr_i.data;
    end
  end

  // Read port holds its data until the next pick
  always_ff @(posedge clk_i) begin
    if (sel_i.valid) begin
      rd_data_q <= mem_q[sel_i.slot];
    end
  end

  assign rd_data_o = rd_data_q;

  // A slot is stored before it is released, never on the same cycle
  a_no_write_read_same_slot: assert property (@(posedge clk_i)
    (sel_i.valid && wr_i.en) |-> (sel_i.slot != wr_i.addr));

endmodule

//--- release_arbiter.sv
// Lowest eligible ID wins and an ID held in the output stage waits until its entry is popped
`timescale 1ns/1ps

module release_arbiter #(
  parameter int unsigned NumSlots = bank_cfg_pkg::MaxSlots
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  bank_xfer_pkg::list_head_t heads_i,
  input  bank_cfg_pkg::slot_mask_t  release_en_i,
  input  logic                      out_ready_i,
  output bank_xfer_pkg::rel_sel_t   sel_o,
  output logic                      out_valid_o,
  output bank_cfg_pkg::slot_mask_t  released_o
);
  import bank_cfg_pkg::*;

  // Output stage
  logic     out_valid_q;
  id_t      out_id_q;
  slot_t    out_slot_q;

  id_mask_t eligible;
  id_t      pick_id;
  logic     found;
  logic     pop;
  logic     can_pick;

  assign pop      = out_valid_q && out_ready_i;
  assign can_pick = !out_valid_q || out_ready_i;

  // Oldest entry of the ID must be enabled by the release mask
  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      eligible[i] = heads_i.has_msg[i] && release_en_i[heads_i.head[i]];
    end
    if (out_valid_q) begin
      eligible[out_id_q] = 1'b0;
    end
  end

  assign found = |eligible;

  // Lowest ID is the last one to match
  always_comb begin
    pick_id = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        pick_id = id_t'(i);
      end
    end
  end

  assign sel_o = '{valid: can_pick && found, id: pick_id, slot: heads_i.head[pick_id]};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (sel_o.valid) begin
      out_valid_q <= 1'b1;
    end else if (pop) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_o.valid) begin
      out_id_q   <= sel_o.id;
      out_slot_q <= sel_o.slot;
    end
  end

  assign out_valid_o = out_valid_q;

  // Freed slot shows up on the pop itself
  assign released_o = pop ? (slot_mask_t'(1) << out_slot_q) : '0;

  a_hold_under_backpressure: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_slot_q)));

  // Picked slots come from the allocator through the lists
  a_pick_in_pool: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sel_o.valid |-> (32'(sel_o.slot) < NumSlots));

endmodule

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass is found in the simulation output
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_write_resp_bank -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "test passed"; then
  exit 0
else
  exit 1
fi

//--- slot_allocator.sv
// Handles up to MaxSlots slots and only frees slots that are reported as released
`timescale 1ns/1ps

module slot_allocator #(
  parameter int unsigned NumSlots = bank_cfg_pkg::MaxSlots
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     resv_ready_i,
  input  bank_cfg_pkg::slot_mask_t free_i,
  output logic                     resv_valid_o,
  output bank_cfg_pkg::slot_t      resv_slot_o
);
  import bank_cfg_pkg::*;

  // Slots that exist in this configuration
  localparam slot_mask_t SlotRange = slot_mask_t'((64'd1 << NumSlots) - 64'd1);

  slot_mask_t occ_q;
  slot_mask_t occ_d;
  slot_mask_t free_slots;
  slot_mask_t resv_onehot;
  logic       resv_fire;

  assign free_slots   = ~occ_q & SlotRange;
  assign resv_valid_o = |free_slots;

  // Lowest free slot wins in a scan from the top down
  always_comb begin
    resv_slot_o = '0;
    for (int s = MaxSlots - 1; s >= 0; s--) begin
      if (free_slots[s]) begin
        resv_slot_o = slot_t'(s);
      end
    end
  end

  assign resv_fire   = resv_valid_o && resv_ready_i;
  assign resv_onehot = resv_fire ? (slot_mask_t'(1) << resv_slot_o) : '0;

  // Released slots are always occupied so set and clear never overlap
  assign occ_d = (occ_q & ~free_i) | resv_onehot;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

  // A slot handed out is never one that the release report still names as held
  a_resv_slot_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resv_fire |-> !free_i[resv_slot_o]);

  // The release report only names slots that are held
  a_free_only_occupied: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (free_i & ~occ_q) == '0);

endmodule

//--- sources.f
bank_cfg_pkg.sv
bank_xfer_pkg.sv
msg_ram_2p.sv
slot_allocator.sv
id_list_ctrl.sv
release_arbiter.sv
write_resp_bank.sv
tb_write_resp_bank.sv

//--- tb_write_resp_bank.sv
// Runs the bank with NumSlots = 32 and stops at the first mismatch and random traffic uses a fixed seed
`timescale 1ns/1ps

module tb_write_resp_bank;
  import bank_cfg_pkg::*;

  localparam int unsigned NumSlots = 32;
  localparam int HalfPeriod = 50;
  localparam int DriveDelay = 1;
  localparam int DrainTimeout = 400;
  localparam int RandomCycles = 4000;

  typedef struct packed {
    slot_t slot;
    msg_t  msg;
  } entry_t;

  logic       clk_i;
  logic       rst_ni;
  id_t        resv_id_i;
  logic       resv_ready_i;
  logic       resv_valid_o;
  slot_t      resv_slot_o;
  logic       in_valid_i;
  msg_t       in_data_i;
  logic       in_ready_o;
  slot_mask_t release_en_i;
  slot_mask_t released_o;
  logic       out_valid_o;
  logic       out_ready_i;
  msg_t       out_data_o;

  // Reference model of reserved but empty slots and stored entries per ID
  slot_t      resv_q [NumIds][$];
  entry_t     stored_q [NumIds][$];
  slot_mask_t occ_m;
  slot_mask_t stored_m;
  slot_mask_t enabled_m;
  logic       held;
  msg_t       held_data;
  int         pop_count;
  int         seed;

  write_resp_bank #(.NumSlots(NumSlots)) u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .resv_id_i    (resv_id_i),
    .resv_ready_i (resv_ready_i),
    .resv_valid_o (resv_valid_o),
    .resv_slot_o  (resv_slot_o),
    .in_valid_i   (in_valid_i),
    .in_data_i    (in_data_i),
    .in_ready_o   (in_ready_o),
    .release_en_i (release_en_i),
    .released_o   (released_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_data_o   (out_data_o)
  );

  always #HalfPeriod clk_i = ~clk_i;

  task automatic fail_run();
    $display("test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic fail_because(input string why);
    $display("%s", why);
    fail_run();
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_slot(input slot_t got, input slot_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_msg(input msg_t got, input msg_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_mask(input slot_mask_t got, input slot_mask_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      fail_run();
    end
  endtask

  // Lowest slot that the model holds as free
  function automatic slot_t lowest_free();
    slot_t slot;
    slot = '0;
    for (int s = NumSlots - 1; s >= 0; s--) begin
      if (!occ_m[s]) begin
        slot = slot_t'(s);
      end
    end
    return slot;
  endfunction

  // Oldest stored entry of an ID is the one that must leave next
  function automatic entry_t expected_entry(input id_t id);
    return stored_q[id][0];
  endfunction

  function automatic msg_t make_msg(input id_t id);
    msg_t m;
    m = {$random(seed), $random(seed)};
    m[IdWidth-1:0] = id;
    return m;
  endfunction

  // Compare mid-cycle, then apply the handshakes of the coming edge to the model
  always @(negedge clk_i) begin : compare_outputs
    entry_t exp;
    entry_t ent;
    id_t    in_id;
    id_t    out_id;
    slot_t  new_slot;
    if (rst_ni) begin
      in_id    = in_data_i[IdWidth-1:0];
      new_slot = lowest_free();
      check_flag(resv_valid_o, occ_m != '1, "resv_valid_o");
      if (resv_valid_o) begin
        check_slot(resv_slot_o, new_slot, "resv_slot_o");
      end
      check_flag(in_ready_o, in_valid_i && resv_q[in_id].size() != 0, "in_ready_o");
      if (held) begin
        check_flag(out_valid_o, 1'b1, "out_valid_o under back-pressure");
        check_msg(out_data_o, held_data, "out_data_o under back-pressure");
      end
      // A stored slot counts as enabled once its mask bit was seen
      enabled_m = enabled_m | (release_en_i & stored_m);
      if (out_valid_o && out_ready_i) begin
        out_id = out_data_o[IdWidth-1:0];
        if (stored_q[out_id].size() == 0) begin
          fail_because($sformatf("A message left for ID %0d with nothing stored", out_id));
        end
        exp = expected_entry(out_id);
        check_msg(out_data_o, exp.msg, "out_data_o");
        check_mask(released_o, slot_mask_t'(1) << exp.slot, "released_o");
        if (!enabled_m[exp.slot]) begin
          fail_because($sformatf("Slot %0d was released without being enabled", exp.slot));
        end
        void'(stored_q[out_id].pop_front());
        occ_m[exp.slot]     = 1'b0;
        stored_m[exp.slot]  = 1'b0;
        enabled_m[exp.slot] = 1'b0;
        pop_count++;
      end else begin
        check_mask(released_o, '0, "released_o");
      end
      if (in_valid_i && in_ready_o) begin
        ent.slot = resv_q[in_id].pop_front();
        ent.msg  = in_data_i;
        stored_q[in_id].push_back(ent);
        stored_m[ent.slot] = 1'b1;
      end
      if (resv_valid_o && resv_ready_i) begin
        occ_m[new_slot] = 1'b1;
        resv_q[resv_id_i].push_back(new_slot);
      end
      held      = out_valid_o && !out_ready_i;
      held_data = out_data_o;
    end
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic reserve(input id_t id);
    resv_id_i    = id;
    resv_ready_i = 1'b1;
    next_cycle();
    resv_ready_i = 1'b0;
  endtask

  task automatic store(input msg_t msg);
    in_valid_i = 1'b1;
    in_data_i  = msg;
    next_cycle();
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (stored_m != '0 || out_valid_o) begin
      if (n == DrainTimeout) begin
        fail_because("Timeout while waiting for the stored messages to leave");
      end else begin
        next_cycle();
        n++;
      end
    end
  endtask

  task automatic fill_and_release_one();
    // IDs 0 to 7 take four slots each and IDs 8 to 15 take none
    for (int i = 0; i < NumSlots; i++) begin
      reserve(id_t'(i % 8));
    end
    check_flag(resv_valid_o, 1'b0, "resv_valid_o with a full pool");
    store(make_msg(id_t'(9)));
    release_en_i = '1;
    out_ready_i  = 1'b1;
    store(make_msg(id_t'(3)));
    wait_drained();
    // Slot 3 was the first reservation of ID 3
    check_flag(resv_valid_o, 1'b1, "resv_valid_o after one release");
    check_slot(resv_slot_o, slot_t'(3), "resv_slot_o after one release");
    reserve(id_t'(3));
    for (int id = 0; id < 8; id++) begin
      while (resv_q[id].size() != 0) begin
        store(make_msg(id_t'(id)));
      end
    end
    wait_drained();
  endtask

  task automatic random_traffic();
    int   hold_cnt;
    id_t  start;
    id_t  id;
    logic found;
    hold_cnt = 0;
    for (int c = 0; c < RandomCycles; c++) begin
      resv_ready_i = ($random(seed) & 1) != 0;
      resv_id_i    = id_t'($random(seed));
      release_en_i = $random(seed) | $random(seed);
      in_valid_i   = ($random(seed) & 3) != 0;
      id           = id_t'($random(seed));
      // Mostly aim at an ID that has an empty reservation
      if (($random(seed) & 3) != 0) begin
        start = id;
        found = 1'b0;
        for (int k = 0; k < NumIds; k++) begin
          if (!found && resv_q[id_t'(int'(start) + k)].size() != 0) begin
            id    = id_t'(int'(start) + k);
            found = 1'b1;
          end
        end
      end
      in_data_i = make_msg(id);
      if (hold_cnt > 0) begin
        out_ready_i = 1'b0;
        hold_cnt--;
      end else if (($random(seed) & 7) == 0) begin
        out_ready_i = 1'b0;
        hold_cnt    = $random(seed) & 7;
      end else begin
        out_ready_i = 1'b1;
      end
      next_cycle();
    end
    resv_ready_i = 1'b0;
    in_valid_i   = 1'b0;
    release_en_i = '1;
    out_ready_i  = 1'b1;
  endtask

  initial begin : run_test
    seed         = 32'h378e_0a37;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    resv_id_i    = '0;
    resv_ready_i = 1'b0;
    in_valid_i   = 1'b0;
    in_data_i    = '0;
    release_en_i = '0;
    out_ready_i  = 1'b0;
    occ_m        = '0;
    stored_m     = '0;
    enabled_m    = '0;
    held         = 1'b0;
    held_data    = '0;
    pop_count    = 0;
    repeat (8) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;
    check_flag(resv_valid_o, 1'b1, "resv_valid_o after reset");
    check_flag(out_valid_o, 1'b0, "out_valid_o after reset");
    check_flag(in_ready_o, 1'b0, "in_ready_o after reset");
    check_mask(released_o, '0, "released_o after reset");
    fill_and_release_one();
    random_traffic();
    wait_drained();
    if (pop_count < 200) begin
      fail_because("Too few messages left the bank during random traffic");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

//--- write_resp_bank.sv
// Write-response bank with NumSlots up to 32 and a slot is always stored before it is released
`timescale 1ns/1ps

module write_resp_bank #(
  parameter int unsigned NumSlots = 32
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Reservation
  input  bank_cfg_pkg::id_t        resv_id_i,
  input  logic                     resv_ready_i,
  output logic                     resv_valid_o,
  output bank_cfg_pkg::slot_t      resv_slot_o,

  // Message input
  input  logic                     in_valid_i,
  input  bank_cfg_pkg::msg_t       in_data_i,
  output logic                     in_ready_o,

  // Release control and report
  input  bank_cfg_pkg::slot_mask_t release_en_i,
  output bank_cfg_pkg::slot_mask_t released_o,

  // Message output
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output bank_cfg_pkg::msg_t       out_data_o
);
  import bank_xfer_pkg::*;

  logic       resv_fire;
  msg_wr_t    wr;
  rel_sel_t   sel;
  list_head_t heads;

  assign resv_fire = resv_valid_o && resv_ready_i;

  slot_allocator #(.NumSlots(NumSlots)) u_slot_allocator (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .resv_ready_i (resv_ready_i),
    .free_i       (released_o),
    .resv_valid_o (resv_valid_o),
    .resv_slot_o  (resv_slot_o)
  );

  id_list_ctrl #(.NumSlots(NumSlots)) u_id_list_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .resv_fire_i (resv_fire),
    .resv_id_i   (resv_id_i),
    .resv_slot_i (resv_slot_o),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .wr_o        (wr),
    .sel_i       (sel),
    .heads_o     (heads)
  );

  msg_ram_2p #(.NumSlots(NumSlots)) u_msg_ram (
    .clk_i     (clk_i),
    .wr_i      (wr),
    .sel_i     (sel),
    .rd_data_o (out_data_o)
  );

  release_arbiter #(.NumSlots(NumSlots)) u_release_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .heads_i      (heads),
    .release_en_i (release_en_i),
    .out_ready_i  (out_ready_i),
    .sel_o        (sel),
    .out_valid_o  (out_valid_o),
    .released_o   (released_o)
  );

endmodule
